//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_accel_top
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

FILE_LIST := accel_top.f
SRCS      := $(filter %.sv,$(shell cat $(FILE_LIST)))
HDRS      := $(wildcard *.svh)
BIN       := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source, a header or the file list changes
$(BIN): $(FILE_LIST) $(SRCS) $(HDRS)
	$(VERILATOR) --binary --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)

run: $(BIN)
	$(BIN) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "TESTS PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- accel_top.f
+incdir+.
conv_pkg.sv
conv_mem_if.sv
dmem_ram.sv
io_dmem_ctrl.sv
conv_engine.sv
conv_regs.sv
accel_top.sv
tb_accel_top.sv

//--- accel_top.sv
`default_nettype none

module accel_top #(
    parameter int DMEM_AW = 14,
    parameter int WT_DIM  = 3
) (
    input  logic               clk,
    input  logic               arst_n_i,

    input  conv_pkg::word_t    cpu_addr_i, // byte address
    input  conv_pkg::word_t    cpu_wdata_i,
    input  conv_pkg::byte_en_t cpu_we_i,   // nonzero means write
    input  logic               cpu_re_i,
    output conv_pkg::word_t    cpu_rdata_o
);
    import conv_pkg::*;

    logic               start;
    logic               soft_rst;
    logic               idle;
    logic               done;
    word_t              fm_dim;
    word_t              wt_off;
    word_t              ifm_off;
    word_t              ofm_off;
    word_t              dmem_rdata;

    logic [DMEM_AW-1:0] a_addr;
    word_t              a_wdata;
    byte_en_t           a_we;
    word_t              a_rdata;
    logic [DMEM_AW-1:0] b_addr;
    word_t              b_wdata;
    byte_en_t           b_we;

    conv_mem_if #(.DMEM_AW(DMEM_AW)) mem_if ();

    dmem_ram #(
        .DMEM_AW(DMEM_AW)
    ) dmem_ram_inst (
        .clk       (clk),
        .a_addr_i  (a_addr),
        .a_wdata_i (a_wdata),
        .a_we_i    (a_we),
        .a_rdata_o (a_rdata),
        .b_addr_i  (b_addr),
        .b_wdata_i (b_wdata),
        .b_we_i    (b_we)
    );

    io_dmem_ctrl #(
        .DMEM_AW(DMEM_AW)
    ) io_dmem_ctrl_inst (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .cpu_addr_i   (cpu_addr_i),
        .cpu_wdata_i  (cpu_wdata_i),
        .cpu_we_i     (cpu_we_i),
        .cpu_re_i     (cpu_re_i),
        .dmem_rdata_o (dmem_rdata),
        .mem          (mem_if.mem),
        .a_addr_o     (a_addr),
        .a_wdata_o    (a_wdata),
        .a_we_o       (a_we),
        .a_rdata_i    (a_rdata),
        .b_addr_o     (b_addr),
        .b_wdata_o    (b_wdata),
        .b_we_o       (b_we)
    );

    conv_regs #(
        .DMEM_AW(DMEM_AW)
    ) conv_regs_inst (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .cpu_addr_i   (cpu_addr_i),
        .cpu_wdata_i  (cpu_wdata_i),
        .cpu_we_i     (cpu_we_i),
        .cpu_re_i     (cpu_re_i),
        .dmem_rdata_i (dmem_rdata),
        .cpu_rdata_o  (cpu_rdata_o),
        .idle_i       (idle),
        .done_i       (done),
        .start_o      (start),
        .soft_rst_o   (soft_rst),
        .fm_dim_o     (fm_dim),
        .wt_off_o     (wt_off),
        .ifm_off_o    (ifm_off),
        .ofm_off_o    (ofm_off)
    );

    conv_engine #(
        .DMEM_AW (DMEM_AW),
        .WT_DIM  (WT_DIM)
    ) conv_engine_inst (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .start_i    (start),
        .soft_rst_i (soft_rst),
        .fm_dim_i   (fm_dim),
        .wt_off_i   (wt_off),
        .ifm_off_i  (ifm_off),
        .ofm_off_i  (ofm_off),
        .idle_o     (idle),
        .done_o     (done),
        .mem        (mem_if.engine)
    );

endmodule

`default_nettype wire

//--- conv_engine.sv
`default_nettype none

module conv_engine #(
    parameter int DMEM_AW = 14,
    parameter int WT_DIM  = 3
) (
    input  logic            clk,
    input  logic            arst_n_i,

    input  logic            start_i,
    input  logic            soft_rst_i,
    input  conv_pkg::word_t fm_dim_i,
    input  conv_pkg::word_t wt_off_i,
    input  conv_pkg::word_t ifm_off_i,
    input  conv_pkg::word_t ofm_off_i,
    output logic            idle_o,
    output logic            done_o,

    conv_mem_if.engine      mem
);
    import conv_pkg::*;

    localparam int    TAPS  = WT_DIM * WT_DIM;
    localparam int    TAP_W = $clog2(TAPS + 1);
    localparam int    K_W   = $clog2(WT_DIM + 1);
    localparam word_t HALF  = word_t'(WT_DIM / 2); // padding on each side

    conv_state_t      state_q;
    logic             wt_phase_q; // reads go to the weight buffer
    logic [TAP_W-1:0] tap_q;
    logic [K_W-1:0]   ky_q;
    logic [K_W-1:0]   kx_q;
    word_t            row_q;
    word_t            col_q;
    word_t            acc_q;
    word_t            weight_q [TAPS];

    word_t row_k;
    word_t col_k;
    word_t in_idx;
    word_t out_idx;
    word_t product;
    logic  tap_in_range;
    logic  tap_last;
    logic  tap_step;
    logic  rd_fire;
    logic  wr_fire;
    logic  rsp_fire;
    logic  col_last;
    logic  row_last;

    assign row_k = row_q + word_t'(ky_q);
    assign col_k = col_q + word_t'(kx_q);
    assign tap_in_range = (row_k >= HALF) && ((row_k - HALF) < fm_dim_i)
                       && (col_k >= HALF) && ((col_k - HALF) < fm_dim_i);
    assign in_idx  = ifm_off_i + (row_k - HALF) * fm_dim_i + (col_k - HALF);
    assign out_idx = ofm_off_i + row_q * fm_dim_i + col_q;

    assign tap_last = tap_q == TAP_W'(TAPS - 1);
    assign col_last = col_q == fm_dim_i - 1;
    assign row_last = row_q == fm_dim_i - 1;

    assign mem.rd_valid = (state_q == ST_LOAD_WT) || ((state_q == ST_TAP) && tap_in_range);
    assign mem.rd_addr  = (state_q == ST_LOAD_WT) ? DMEM_AW'(wt_off_i + word_t'(tap_q))
                                                  : in_idx[DMEM_AW-1:0];
    assign mem.wr_valid = state_q == ST_WRITE;
    assign mem.wr_addr  = out_idx[DMEM_AW-1:0];
    assign mem.wr_data  = acc_q;

    assign rd_fire  = mem.rd_valid && mem.rd_ready;
    assign wr_fire  = mem.wr_valid && mem.wr_ready;
    assign rsp_fire = (state_q == ST_WAIT_RD) && mem.rd_data_valid;
    assign tap_step = rsp_fire || ((state_q == ST_TAP) && !tap_in_range); // padded taps skip

    assign product = weight_q[tap_q] * mem.rd_data; // low 32 bits match the signed product

    assign idle_o = (state_q == ST_IDLE) || (state_q == ST_DONE);
    assign done_o = state_q == ST_DONE;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q    <= ST_IDLE;
            wt_phase_q <= 1'b0;
            tap_q      <= '0;
            ky_q       <= '0;
            kx_q       <= '0;
            row_q      <= '0;
            col_q      <= '0;
        end else if (soft_rst_i) begin
            state_q    <= ST_IDLE; // config regs live elsewhere and stay
            wt_phase_q <= 1'b0;
        end else begin
            if (tap_step) begin
                if (tap_last) begin
                    tap_q <= '0;
                    ky_q  <= '0;
                    kx_q  <= '0;
                end else begin
                    tap_q <= tap_q + 1'b1;
                    if (kx_q == K_W'(WT_DIM - 1)) begin
                        kx_q <= '0;
                        ky_q <= ky_q + 1'b1;
                    end else begin
                        kx_q <= kx_q + 1'b1;
                    end
                end
            end
            case (state_q)
                ST_IDLE, ST_DONE: begin
                    if (start_i) begin
                        state_q    <= ST_LOAD_WT;
                        wt_phase_q <= 1'b1;
                        tap_q      <= '0;
                        ky_q       <= '0;
                        kx_q       <= '0;
                        row_q      <= '0;
                        col_q      <= '0;
                    end
                end
                ST_LOAD_WT: begin
                    if (rd_fire) state_q <= ST_WAIT_RD;
                end
                ST_WAIT_RD: begin
                    if (mem.rd_data_valid) begin
                        if (!tap_last) begin
                            state_q <= wt_phase_q ? ST_LOAD_WT : ST_TAP;
                        end else if (wt_phase_q) begin
                            state_q    <= ST_TAP; // kernel loaded so on to the first pixel
                            wt_phase_q <= 1'b0;
                        end else begin
                            state_q <= ST_WRITE;
                        end
                    end
                end
                ST_TAP: begin
                    if (!tap_in_range) begin
                        if (tap_last) state_q <= ST_WRITE;
                    end else if (rd_fire) begin
                        state_q <= ST_WAIT_RD;
                    end
                end
                ST_WRITE: begin
                    if (wr_fire) begin
                        state_q <= ST_TAP;
                        if (!col_last) begin
                            col_q <= col_q + 1'b1;
                        end else begin
                            col_q <= '0;
                            row_q <= row_q + 1'b1;
                            if (row_last) state_q <= ST_DONE;
                        end
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rsp_fire && wt_phase_q) weight_q[tap_q] <= mem.rd_data;
        if (wt_phase_q || wr_fire) begin
            acc_q <= '0; // fresh sum for the next pixel
        end else if (rsp_fire) begin
            acc_q <= acc_q + product; // wraps
        end
    end

endmodule

`default_nettype wire

//--- conv_mem_if.sv
`default_nettype none

interface conv_mem_if #(
    parameter int DMEM_AW = 14
);
    import conv_pkg::*;

    logic [DMEM_AW-1:0] rd_addr;       // word address
    logic               rd_valid;
    logic               rd_ready;      // low while the cpu owns port a
    word_t              rd_data;
    logic               rd_data_valid; // one cycle after accepted read

    logic [DMEM_AW-1:0] wr_addr;
    word_t              wr_data;
    logic               wr_valid;
    logic               wr_ready;

    modport engine (
        output rd_addr,
        output rd_valid,
        input  rd_ready,
        input  rd_data,
        input  rd_data_valid,
        output wr_addr,
        output wr_data,
        output wr_valid,
        input  wr_ready
    );

    modport mem (
        input  rd_addr,
        input  rd_valid,
        output rd_ready,
        output rd_data,
        output rd_data_valid,
        input  wr_addr,
        input  wr_data,
        input  wr_valid,
        output wr_ready
    );

endinterface

`default_nettype wire

//--- conv_pkg.sv
`default_nettype none

package conv_pkg;

    typedef logic [31:0] word_t;   // one data word
    typedef logic [3:0]  byte_en_t; // per-byte write enables

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_LOAD_WT,                // fetch kernel into local regs
        ST_TAP,                    // pick next tap, skip if padded
        ST_WAIT_RD,                // read response due this cycle
        ST_WRITE,                  // store one output pixel
        ST_DONE
    } conv_state_t;

    // data memory region decoded on bits 31:30 and 28
    localparam word_t DMEM_BASE = 32'h1000_0000;

    // convolution register block
    localparam word_t CONV_BASE = 32'h8000_0040;

    localparam word_t REG_CTRL    = 32'h0000_0000;
    localparam word_t REG_STATUS  = 32'h0000_0004;
    localparam word_t REG_FM_DIM  = 32'h0000_0008;
    localparam word_t REG_WT_OFF  = 32'h0000_000C; // word index into data memory
    localparam word_t REG_IFM_OFF = 32'h0000_0010; // word index into data memory
    localparam word_t REG_OFM_OFF = 32'h0000_0014; // word index into data memory

    localparam int CTRL_START_BIT = 0;
    localparam int CTRL_RST_BIT   = 1;

    localparam int STAT_IDLE_BIT = 0;
    localparam int STAT_DONE_BIT = 1;

endpackage

`default_nettype wire

//--- conv_regs.sv
`default_nettype none

module conv_regs #(
    parameter int DMEM_AW = 14
) (
    input  logic               clk,
    input  logic               arst_n_i,

    input  conv_pkg::word_t    cpu_addr_i,
    input  conv_pkg::word_t    cpu_wdata_i,
    input  conv_pkg::byte_en_t cpu_we_i,
    input  logic               cpu_re_i,
    input  conv_pkg::word_t    dmem_rdata_i,
    output conv_pkg::word_t    cpu_rdata_o,

    input  logic               idle_i,
    input  logic               done_i,
    output logic               start_o,
    output logic               soft_rst_o,
    output conv_pkg::word_t    fm_dim_o,
    output conv_pkg::word_t    wt_off_o,
    output conv_pkg::word_t    ifm_off_o,
    output conv_pkg::word_t    ofm_off_o
);
    import conv_pkg::*;

    logic  in_conv;
    logic  reg_wr;
    logic  ctrl_wr;
    logic  fm_dim_ok;
    word_t reg_off;
    word_t status;
    word_t rd_sel;
    word_t rdata_q;

    assign in_conv = cpu_addr_i[31:5] == CONV_BASE[31:5];
    assign reg_off = cpu_addr_i - CONV_BASE;
    assign reg_wr  = in_conv && (cpu_we_i != '0); // any strobe writes the whole word
    assign ctrl_wr = reg_wr && (reg_off == REG_CTRL);

    // side must be nonzero and the map must fit the data memory
    assign fm_dim_ok = (fm_dim_o != '0) && ((fm_dim_o >> ((DMEM_AW + 1) / 2)) == '0);

    assign start_o    = ctrl_wr && cpu_wdata_i[CTRL_START_BIT] && idle_i && fm_dim_ok;
    assign soft_rst_o = ctrl_wr && cpu_wdata_i[CTRL_RST_BIT];

    always_comb begin
        status                = '0;
        status[STAT_IDLE_BIT] = idle_i;
        status[STAT_DONE_BIT] = done_i;
    end

    always_comb begin
        case (reg_off)
            REG_STATUS:  rd_sel = status;
            REG_FM_DIM:  rd_sel = fm_dim_o;
            REG_WT_OFF:  rd_sel = wt_off_o;
            REG_IFM_OFF: rd_sel = ifm_off_o;
            REG_OFM_OFF: rd_sel = ofm_off_o;
            default:     rd_sel = '0; // ctrl is write-only
        endcase
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            fm_dim_o  <= '0;
            wt_off_o  <= '0;
            ifm_off_o <= '0;
            ofm_off_o <= '0;
            rdata_q   <= '0;
        end else begin
            if (reg_wr) begin
                case (reg_off)
                    REG_FM_DIM:  fm_dim_o  <= cpu_wdata_i;
                    REG_WT_OFF:  wt_off_o  <= cpu_wdata_i;
                    REG_IFM_OFF: ifm_off_o <= cpu_wdata_i;
                    REG_OFM_OFF: ofm_off_o <= cpu_wdata_i;
                    default: ;
                endcase
            end
            rdata_q <= (cpu_re_i && in_conv) ? rd_sel : '0;
        end
    end

    // both sources are zero unless their own read happened last cycle
    assign cpu_rdata_o = rdata_q | dmem_rdata_i;

endmodule

`default_nettype wire

//--- dmem_ram.sv
`default_nettype none

module dmem_ram #(
    parameter int DMEM_AW = 14
) (
    input  logic               clk,

    input  logic [DMEM_AW-1:0] a_addr_i,
    input  conv_pkg::word_t    a_wdata_i,
    input  conv_pkg::byte_en_t a_we_i,
    output conv_pkg::word_t    a_rdata_o,

    input  logic [DMEM_AW-1:0] b_addr_i,
    input  conv_pkg::word_t    b_wdata_i,
    input  conv_pkg::byte_en_t b_we_i
);
    import conv_pkg::*;

    localparam int DEPTH = 2 ** DMEM_AW;

    word_t mem_q [DEPTH];

    always_ff @(posedge clk) begin
        for (int i = 0; i < 4; i++) begin
            if (a_we_i[i]) begin
                mem_q[a_addr_i][8*i +: 8] <= a_wdata_i[8*i +: 8];
            end
            if (b_we_i[i]) begin
                mem_q[b_addr_i][8*i +: 8] <= b_wdata_i[8*i +: 8]; // port b wins a collision
            end
        end
        a_rdata_o <= mem_q[a_addr_i]; // read-first with one cycle latency
    end

endmodule

`default_nettype wire

//--- io_dmem_ctrl.sv
`default_nettype none

module io_dmem_ctrl #(
    parameter int DMEM_AW = 14
) (
    input  logic               clk,
    input  logic               arst_n_i,

    input  conv_pkg::word_t    cpu_addr_i,
    input  conv_pkg::word_t    cpu_wdata_i,
    input  conv_pkg::byte_en_t cpu_we_i,
    input  logic               cpu_re_i,
    output conv_pkg::word_t    dmem_rdata_o,

    conv_mem_if.mem            mem,

    output logic [DMEM_AW-1:0] a_addr_o,
    output conv_pkg::word_t    a_wdata_o,
    output conv_pkg::byte_en_t a_we_o,
    input  conv_pkg::word_t    a_rdata_i,

    output logic [DMEM_AW-1:0] b_addr_o,
    output conv_pkg::word_t    b_wdata_o,
    output conv_pkg::byte_en_t b_we_o
);
    import conv_pkg::*;

    logic in_dmem;
    logic cpu_hit;
    logic cpu_rd_q; // port a read last cycle was the cpu's
    logic eng_rd_q; // port a read last cycle was the engine's

    assign in_dmem = (cpu_addr_i[31:30] == DMEM_BASE[31:30])
                  && (cpu_addr_i[28] == DMEM_BASE[28]);
    assign cpu_hit = in_dmem && (cpu_re_i || (cpu_we_i != '0));

    // cpu always takes port a so engine reads wait
    assign mem.rd_ready = !cpu_hit;
    assign a_addr_o     = cpu_hit ? cpu_addr_i[DMEM_AW+1:2] : mem.rd_addr;
    assign a_wdata_o    = cpu_wdata_i;
    assign a_we_o       = in_dmem ? cpu_we_i : '0;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            cpu_rd_q <= 1'b0;
            eng_rd_q <= 1'b0;
        end else begin
            cpu_rd_q <= in_dmem && cpu_re_i;
            eng_rd_q <= mem.rd_valid && mem.rd_ready;
        end
    end

    assign mem.rd_data       = a_rdata_i;
    assign mem.rd_data_valid = eng_rd_q;
    assign dmem_rdata_o      = cpu_rd_q ? a_rdata_i : '0;

    // port b belongs to engine writes alone
    assign mem.wr_ready = 1'b1;
    assign b_addr_o     = mem.wr_addr;
    assign b_wdata_o    = mem.wr_data;
    assign b_we_o       = mem.wr_valid ? 4'hF : 4'h0; // full word store

endmodule

`default_nettype wire

//--- tb_conv_model.svh
`ifndef TB_CONV_MODEL_SVH
`define TB_CONV_MODEL_SVH

word_t model_mem [2**DMEM_AW]; // mirror of the data memory

task automatic model_write(input int idx, input word_t data, input byte_en_t mask);
    for (int b = 0; b < 4; b++) begin
        if (mask[b]) model_mem[idx][8*b +: 8] = data[8*b +: 8];
    end
endtask

// zero-padded same-size convolution into the model output area
task automatic model_convolve(input int dim, input int wt, input int ifm, input int ofm);
    int acc;
    int r_in;
    int c_in;
    for (int r = 0; r < dim; r++) begin
        for (int c = 0; c < dim; c++) begin
            acc = 0;
            for (int ky = 0; ky < WT_DIM; ky++) begin
                for (int kx = 0; kx < WT_DIM; kx++) begin
                    r_in = r + ky - WT_DIM / 2;
                    c_in = c + kx - WT_DIM / 2;
                    if (r_in >= 0 && r_in < dim && c_in >= 0 && c_in < dim) begin
                        acc += int'(model_mem[wt + ky * WT_DIM + kx])
                             * int'(model_mem[ifm + r_in * dim + c_in]); // 32-bit wrap
                    end
                end
            end
            model_mem[ofm + r * dim + c] = word_t'(acc);
        end
    end
endtask

task automatic check_word(input string name, input word_t expected, input word_t actual);
    checks++;
    if (actual !== expected) begin
        errors++;
        $display("MISMATCH %s expected 0x%08h actual 0x%08h", name, expected, actual);
    end
endtask

task automatic check_status(input word_t expected, input word_t actual);
    checks++;
    if (actual !== expected) begin
        errors++;
        $display("MISMATCH status expected 0x%08h actual 0x%08h", expected, actual);
    end
endtask

`endif

//--- tb_accel_top.sv
`default_nettype none

module tb_accel_top;
    import conv_pkg::*;

    localparam int    DMEM_AW     = 14;
    localparam int    WT_DIM      = 3;
    localparam int    TAPS        = WT_DIM * WT_DIM;
    localparam int    POLL_LIMIT  = 5000; // status reads before giving up
    localparam word_t SEED        = 32'd55777;
    localparam word_t STATUS_IDLE = word_t'(1) << STAT_IDLE_BIT;
    localparam word_t STATUS_DONE = word_t'(1) << STAT_DONE_BIT;

    logic     clk;
    logic     arst_n_i;
    word_t    cpu_addr_i;
    word_t    cpu_wdata_i;
    byte_en_t cpu_we_i;
    logic     cpu_re_i;
    word_t    cpu_rdata_o;

    word_t lfsr_q;
    int    errors;
    int    checks;
    int    tests_run;

    `include "tb_conv_model.svh"

    accel_top #(
        .DMEM_AW (DMEM_AW),
        .WT_DIM  (WT_DIM)
    ) accel_top_inst (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .cpu_addr_i  (cpu_addr_i),
        .cpu_wdata_i (cpu_wdata_i),
        .cpu_we_i    (cpu_we_i),
        .cpu_re_i    (cpu_re_i),
        .cpu_rdata_o (cpu_rdata_o)
    );

    always #2 clk = ~clk;

    function automatic word_t lfsr_next(input word_t s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1); // galois form shifting right
    endfunction

    function automatic word_t rand_bits(input int n);
        word_t r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_next(lfsr_q); // one step per bit
            r = {r[30:0], lfsr_q[0]};
        end
        return r;
    endfunction

    function automatic word_t dmem_addr(input int idx);
        return DMEM_BASE + word_t'(idx) * 4;
    endfunction

    task automatic bus_write(input word_t addr, input word_t data, input byte_en_t mask);
        @(posedge clk);
        cpu_addr_i  <= addr;
        cpu_wdata_i <= data;
        cpu_we_i    <= mask;
        @(posedge clk);
        cpu_we_i    <= '0;
    endtask

    task automatic bus_read(input word_t addr, output word_t data);
        @(posedge clk);
        cpu_addr_i <= addr;
        cpu_re_i   <= 1'b1;
        @(posedge clk);
        cpu_re_i   <= 1'b0;
        @(negedge clk);
        data = cpu_rdata_o; // read data sits in the cycle after the strobe
    endtask

    task automatic mem_store(input int idx, input word_t data, input byte_en_t mask);
        bus_write(dmem_addr(idx), data, mask);
        model_write(idx, data, mask);
    endtask

    task automatic fill_random(input int base, input int count);
        for (int i = 0; i < count; i++) begin
            mem_store(base + i, rand_bits(32), 4'hF);
        end
    endtask

    task automatic read_check_mem(input int idx);
        word_t d;
        bus_read(dmem_addr(idx), d);
        check_word($sformatf("cpu_rdata_o dmem[%0h]", idx), model_mem[idx], d);
    endtask

    // one read per cycle with each check at the negedge that follows
    task automatic burst_check(input int base, input int count);
        for (int i = 0; i <= count; i++) begin
            @(posedge clk);
            cpu_re_i <= i < count;
            if (i < count) cpu_addr_i <= dmem_addr(base + i);
            if (i > 0) begin
                @(negedge clk);
                check_word($sformatf("cpu_rdata_o dmem[%0h]", base + i - 1),
                           model_mem[base + i - 1], cpu_rdata_o);
            end
        end
    endtask

    task automatic reg_write(input word_t off, input word_t data);
        bus_write(CONV_BASE + off, data, 4'hF);
    endtask

    task automatic run_conv(input int dim, input int wt, input int ifm, input int ofm);
        fill_random(wt, TAPS);
        fill_random(ifm, dim * dim);
        reg_write(REG_FM_DIM, word_t'(dim));
        reg_write(REG_WT_OFF, word_t'(wt));
        reg_write(REG_IFM_OFF, word_t'(ifm));
        reg_write(REG_OFM_OFF, word_t'(ofm));
        model_convolve(dim, wt, ifm, ofm);
        reg_write(REG_CTRL, word_t'(1) << CTRL_START_BIT);
    endtask

    task automatic wait_done();
        word_t st;
        int    polls;
        st    = '0;
        polls = 0;
        while (st !== (STATUS_IDLE | STATUS_DONE) && polls < POLL_LIMIT) begin
            bus_read(CONV_BASE + REG_STATUS, st);
            polls++;
        end
        if (st !== (STATUS_IDLE | STATUS_DONE)) begin
            errors++;
            $display("engine still busy after %0d status reads, run timed out", polls);
        end
    endtask

    task automatic verify_output(input int dim, input int ofm);
        for (int i = 0; i < dim * dim; i++) begin
            read_check_mem(ofm + i);
        end
    endtask

    task automatic report_test(input string name, input int err_before);
        tests_run++;
        if (errors == err_before) begin
            $display("test %0d %s ok", tests_run, name);
        end else begin
            $display("test %0d %s %0d errors", tests_run, name, errors - err_before);
        end
    endtask

    task automatic test_reset_values();
        word_t offs [4] = '{REG_FM_DIM, REG_WT_OFF, REG_IFM_OFF, REG_OFM_OFF};
        word_t d;
        int    e0;
        e0 = errors;
        bus_read(CONV_BASE + REG_STATUS, d);
        check_status(STATUS_IDLE, d);
        foreach (offs[i]) begin
            bus_read(CONV_BASE + offs[i], d);
            check_word($sformatf("cpu_rdata_o reg 0x%0h", offs[i]), '0, d);
        end
        report_test("reset_values", e0);
    endtask

    task automatic test_mem_bytes();
        int e0;
        e0 = errors;
        fill_random(32'h1000, 32); // defined contents first
        for (int i = 0; i < 64; i++) begin
            mem_store(32'h1000 + int'(rand_bits(5)), rand_bits(32), byte_en_t'(rand_bits(4)));
        end
        for (int i = 0; i < 32; i++) begin
            read_check_mem(32'h1000 + i);
        end
        report_test("mem_bytes", e0);
    endtask

    task automatic test_reg_rw();
        word_t offs [4] = '{REG_FM_DIM, REG_WT_OFF, REG_IFM_OFF, REG_OFM_OFF};
        word_t v;
        word_t d;
        int    e0;
        e0 = errors;
        foreach (offs[i]) begin
            v = rand_bits(32);
            reg_write(offs[i], v);
            bus_read(CONV_BASE + offs[i], d);
            check_word($sformatf("cpu_rdata_o reg 0x%0h", offs[i]), v, d);
        end
        report_test("reg_rw", e0);
    endtask

    task automatic test_full_run();
        int e0;
        e0 = errors;
        run_conv(8, 32'h100, 32'h100 + TAPS, 32'h400); // input right after weights
        wait_done();
        verify_output(8, 32'h400);
        report_test("full_run", e0);
    endtask

    task automatic test_cpu_interference();
        int e0;
        e0 = errors;
        run_conv(8, 32'h100, 32'h100 + TAPS, 32'h400);
        burst_check(32'h100, TAPS + 64); // weights and input in one burst
        wait_done();
        verify_output(8, 32'h400);
        report_test("cpu_interference", e0);
    endtask

    task automatic test_soft_reset();
        word_t d;
        int    e0;
        e0 = errors;
        run_conv(8, 32'h100, 32'h100 + TAPS, 32'h400);
        repeat (200) @(posedge clk); // well inside the run
        bus_read(CONV_BASE + REG_STATUS, d);
        check_status('0, d);
        reg_write(REG_CTRL, word_t'(1) << CTRL_RST_BIT);
        bus_read(CONV_BASE + REG_STATUS, d);
        check_status(STATUS_IDLE, d);
        run_conv(5, 32'h600, 32'h700, 32'h800);
        wait_done();
        verify_output(5, 32'h800);
        report_test("soft_reset", e0);
    endtask

    initial begin
        clk         = 1'b0;
        arst_n_i    = 1'b0;
        cpu_addr_i  = '0;
        cpu_wdata_i = '0;
        cpu_we_i    = '0;
        cpu_re_i    = 1'b0;
        lfsr_q      = SEED;
        errors      = 0;
        checks      = 0;
        tests_run   = 0;
        repeat (3) @(posedge clk);
        arst_n_i <= 1'b1;

        test_reset_values();
        test_mem_bytes();
        test_reg_rw();
        test_full_run();
        test_cpu_interference();
        test_soft_reset();

        $display("summary: %0d tests, %0d checks, %0d errors", tests_run, checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
